// File: common/mem_link_pkg.sv
package mem_link_pkg;

  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 16;
  localparam int LOAD_ID_W  = 8;
  localparam int MASK_W     = DATA_W / 8;
  // top address bit is configuration space, memory sees the rest
  localparam int MEM_ADDR_W = ADDR_W - 1;

  typedef enum logic [1:0] {
    LOAD   = 2'd0,
    STORE  = 2'd1,
    CFG_RD = 2'd2,
    CFG_WR = 2'd3
  } link_op_e;

  typedef enum logic [1:0] {
    MODE   = 2'd0,
    HITS   = 2'd1,
    MISSES = 2'd2,
    ERR    = 2'd3
  } cfg_reg_e;

  typedef struct packed {
    logic [DATA_W-4:0] pad;
    logic              clear;
    logic              no_mem;
    logic              bypass;
  } cfg_fields_s;

  // payload word, store data or config fields
  typedef union packed {
    logic [DATA_W-1:0] data;
    cfg_fields_s       cfg;
  } link_payload_u;

  typedef struct packed {
    link_op_e         op;
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
    link_payload_u    payload;
    logic [LOAD_ID_W-1:0] load_id;
  } link_req_s;

  typedef struct packed {
    logic [LOAD_ID_W-1:0] load_id;
    logic [DATA_W-1:0]    data;
  } link_resp_s;

  typedef struct packed {
    logic                  write;
    logic [MEM_ADDR_W-1:0] addr;
    logic [MASK_W-1:0]     mask;
    logic [DATA_W-1:0]     data;
  } mem_req_s;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } mem_resp_s;

  typedef struct packed {
    logic bypass;
    logic no_mem;
  } vc_mode_s;

  typedef struct packed {
    logic hit;
    logic miss;
    logic mem_access;
  } vc_event_s;

  // byte-masked merge, shared by the cache line and the memory array
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [MASK_W-1:0] mask
  );
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < MASK_W; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: rtl/link_fifo.sv
`timescale 1ns/1ps

module link_fifo import mem_link_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  link_req_s in_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output link_req_s out_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  link_req_s  buf_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  assign in_ready_o  = (count_r != 2'd2);
  assign out_valid_o = (count_r != 2'd0);
  assign out_o       = buf_r[rd_ptr_r];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) wr_ptr_r <= ~wr_ptr_r;
      if (pop) rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_r[wr_ptr_r] <= in_i;
    end
  end

endmodule

// File: vcache/vcache_bank.sv
`timescale 1ns/1ps

module vcache_bank import mem_link_pkg::*; #(
  parameter int SETS_P = 16
) (
  input  logic              clk,
  input  logic              reset,

  input  link_req_s         req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,

  output link_resp_s        resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,

  output mem_req_s          mem_req_o,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  input  mem_resp_s         mem_resp_i,
  input  logic              mem_resp_valid_i,

  input  vc_mode_s          mode_i,
  output vc_event_s         event_o,

  output logic              cfg_strobe_o,
  output logic              cfg_write_o,
  output cfg_reg_e          cfg_idx_o,
  output link_payload_u     cfg_wdata_o,
  input  logic [DATA_W-1:0] cfg_rdata_i
);

  localparam int IDX_W = $clog2(SETS_P);
  localparam int TAG_W = MEM_ADDR_W - IDX_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_MEM_ISSUE,
    S_MEM_WAIT,
    S_RESPOND
  } state_e;

  state_e state_r;
  state_e state_n;

  logic [SETS_P-1:0] valid_r;
  logic [TAG_W-1:0]  tag_r [SETS_P];
  logic [DATA_W-1:0] data_r [SETS_P];

  link_req_s         req_q;
  logic [DATA_W-1:0] resp_data_r;

  logic             accept;
  logic             is_cfg;
  logic             is_load;
  logic             hit;
  logic             load_hit;
  logic             need_mem;
  logic             fill;
  logic             store_hit_wr;
  logic [IDX_W-1:0] in_idx;
  logic [TAG_W-1:0] in_tag;
  logic [IDX_W-1:0] q_idx;
  logic [TAG_W-1:0] q_tag;

  assign req_ready_o = (state_r == S_IDLE);
  assign accept      = req_valid_i && req_ready_o;

  // config space by address bit or by opcode
  assign is_cfg  = req_i.addr[ADDR_W-1] || (req_i.op == CFG_RD) || (req_i.op == CFG_WR);
  assign is_load = !is_cfg && (req_i.op == LOAD);

  assign in_idx   = req_i.addr[IDX_W-1:0];
  assign in_tag   = req_i.addr[MEM_ADDR_W-1:IDX_W];
  assign hit      = valid_r[in_idx] && (tag_r[in_idx] == in_tag);
  assign load_hit = is_load && hit && !mode_i.bypass;
  // every store writes through, loads go out unless served here
  assign need_mem = !is_cfg && !load_hit;

  assign q_idx = req_q.addr[IDX_W-1:0];
  assign q_tag = req_q.addr[MEM_ADDR_W-1:IDX_W];

  assign event_o.hit        = accept && load_hit;
  assign event_o.miss       = accept && is_load && !load_hit;
  assign event_o.mem_access = accept && need_mem;

  assign cfg_strobe_o = accept && is_cfg;
  assign cfg_write_o  = (req_i.op == CFG_WR) || (req_i.op == STORE);
  assign cfg_idx_o    = cfg_reg_e'(req_i.addr[1:0]);
  assign cfg_wdata_o  = req_i.payload;

  always_comb begin
    state_n = state_r;
    case (state_r)
      S_IDLE: begin
        if (accept) begin
          state_n = (need_mem && !mode_i.no_mem) ? S_MEM_ISSUE : S_RESPOND;
        end
      end
      S_MEM_ISSUE: begin
        if (mem_req_ready_i) begin
          state_n = mem_req_o.write ? S_RESPOND : S_MEM_WAIT;
        end
      end
      S_MEM_WAIT: begin
        if (mem_resp_valid_i) state_n = S_RESPOND;
      end
      S_RESPOND: begin
        if (resp_ready_i) state_n = S_IDLE;
      end
      default: state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r <= S_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // request copy and response word
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
      if (is_cfg && !cfg_write_o) begin
        resp_data_r <= cfg_rdata_i;
      end else if (load_hit) begin
        resp_data_r <= data_r[in_idx];
      end else begin
        resp_data_r <= '0;
      end
    end else if (state_r == S_MEM_WAIT && mem_resp_valid_i) begin
      resp_data_r <= mem_resp_i.data;
    end
  end

  // fill on load miss, never in bypass
  assign fill = (state_r == S_MEM_WAIT) && mem_resp_valid_i
             && (req_q.op == LOAD) && !mode_i.bypass;
  assign store_hit_wr = accept && !is_cfg && !is_load && hit && !mode_i.no_mem;

  always_ff @(posedge clk) begin
    if (!reset) begin
      valid_r <= '0;
    end else if (fill) begin
      valid_r[q_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_r[q_idx]  <= q_tag;
      data_r[q_idx] <= mem_resp_i.data;
    end else if (store_hit_wr) begin
      data_r[in_idx] <= merge_bytes(data_r[in_idx], req_i.payload.data, req_i.mask);
    end
  end

  assign mem_req_valid_o = (state_r == S_MEM_ISSUE);
  assign mem_req_o.write = (req_q.op != LOAD);
  assign mem_req_o.addr  = req_q.addr[MEM_ADDR_W-1:0];
  assign mem_req_o.mask  = req_q.mask;
  assign mem_req_o.data  = req_q.payload.data;

  assign resp_valid_o   = (state_r == S_RESPOND);
  assign resp_o.load_id = req_q.load_id;
  assign resp_o.data    = resp_data_r;

endmodule

// File: vcache/vcache_csr.sv
`timescale 1ns/1ps

module vcache_csr import mem_link_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              cfg_strobe_i,
  input  logic              cfg_write_i,
  input  cfg_reg_e          cfg_idx_i,
  input  link_payload_u     cfg_wdata_i,
  output logic [DATA_W-1:0] cfg_rdata_o,
  input  vc_event_s         event_i,
  output vc_mode_s          mode_o
);

  vc_mode_s          mode_r;
  logic [DATA_W-1:0] hits_r;
  logic [DATA_W-1:0] misses_r;
  logic              err_r;
  logic              wr;
  cfg_fields_s       mode_view;

  assign wr = cfg_strobe_i && cfg_write_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      mode_r   <= '0;
      hits_r   <= '0;
      misses_r <= '0;
      err_r    <= 1'b0;
    end else begin
      if (wr && cfg_idx_i == MODE) begin
        mode_r.bypass <= cfg_wdata_i.cfg.bypass;
        mode_r.no_mem <= cfg_wdata_i.cfg.no_mem;
      end
      // clear wins over a same-cycle count
      if (wr && cfg_idx_i == MODE && cfg_wdata_i.cfg.clear) begin
        hits_r   <= '0;
        misses_r <= '0;
      end else begin
        if (event_i.hit) hits_r <= hits_r + 1'b1;
        if (event_i.miss) misses_r <= misses_r + 1'b1;
      end
      // sticky until written
      if (event_i.mem_access && mode_r.no_mem) begin
        err_r <= 1'b1;
      end else if (wr && cfg_idx_i == ERR) begin
        err_r <= 1'b0;
      end
    end
  end

  always_comb begin
    mode_view        = '0;
    mode_view.bypass = mode_r.bypass;
    mode_view.no_mem = mode_r.no_mem;
  end

  always_comb begin
    case (cfg_idx_i)
      MODE:    cfg_rdata_o = mode_view;
      HITS:    cfg_rdata_o = hits_r;
      MISSES:  cfg_rdata_o = misses_r;
      ERR:     cfg_rdata_o = {{(DATA_W-1){1'b0}}, err_r};
      default: cfg_rdata_o = '0;
    endcase
  end

  assign mode_o = mode_r;

endmodule

// File: rtl/dram_model.sv
`timescale 1ns/1ps

module dram_model import mem_link_pkg::*; #(
  parameter int MEM_LATENCY_P = 3
) (
  input  logic      clk,
  input  logic      reset,
  input  mem_req_s  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output mem_resp_s resp_o,
  output logic      resp_valid_o
);

  localparam int MEM_WORDS = 2 ** MEM_ADDR_W;
  localparam int CNT_W     = $clog2(MEM_LATENCY_P + 1);

  logic [DATA_W-1:0] mem_r [MEM_WORDS] = '{default: '0};
  logic [DATA_W-1:0] rdata_r;
  logic [CNT_W-1:0]  cnt_r;
  logic              accept;

  // one request at a time, busy while a read counts down
  assign req_ready_o = (cnt_r == '0);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (!reset) begin
      cnt_r <= '0;
    end else if (accept && !req_i.write) begin
      cnt_r <= CNT_W'(MEM_LATENCY_P);
    end else if (cnt_r != '0) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  // writes complete on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      if (req_i.write) begin
        mem_r[req_i.addr] <= merge_bytes(mem_r[req_i.addr], req_i.data, req_i.mask);
      end else begin
        rdata_r <= mem_r[req_i.addr];
      end
    end
  end

  // last count cycle, so data returns MEM_LATENCY_P edges after accept
  assign resp_valid_o = (cnt_r == CNT_W'(1));
  assign resp_o.data  = rdata_r;

endmodule

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import mem_link_pkg::*; #(
  parameter int SETS_P        = 16,
  parameter int MEM_LATENCY_P = 3
) (
  input  logic       clk,
  input  logic       reset,
  input  link_req_s  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output link_resp_s resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  link_req_s         fifo_req;
  logic              fifo_valid;
  logic              bank_ready;

  mem_req_s          mem_req;
  logic              mem_req_valid;
  logic              mem_req_ready;
  mem_resp_s         mem_resp;
  logic              mem_resp_valid;

  vc_mode_s          mode;
  vc_event_s         events;
  logic              cfg_strobe;
  logic              cfg_write;
  cfg_reg_e          cfg_idx;
  link_payload_u     cfg_wdata;
  logic [DATA_W-1:0] cfg_rdata;

  link_fifo u_link_fifo (
    .clk         (clk),
    .reset       (reset),
    .in_i        (req_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .out_o       (fifo_req),
    .out_valid_o (fifo_valid),
    .out_ready_i (bank_ready)
  );

  vcache_bank #(
    .SETS_P (SETS_P)
  ) u_vcache_bank (
    .clk              (clk),
    .reset            (reset),
    .req_i            (fifo_req),
    .req_valid_i      (fifo_valid),
    .req_ready_o      (bank_ready),
    .resp_o           (resp_o),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .mem_req_o        (mem_req),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_resp_i       (mem_resp),
    .mem_resp_valid_i (mem_resp_valid),
    .mode_i           (mode),
    .event_o          (events),
    .cfg_strobe_o     (cfg_strobe),
    .cfg_write_o      (cfg_write),
    .cfg_idx_o        (cfg_idx),
    .cfg_wdata_o      (cfg_wdata),
    .cfg_rdata_i      (cfg_rdata)
  );

  vcache_csr u_vcache_csr (
    .clk          (clk),
    .reset        (reset),
    .cfg_strobe_i (cfg_strobe),
    .cfg_write_i  (cfg_write),
    .cfg_idx_i    (cfg_idx),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_rdata_o  (cfg_rdata),
    .event_i      (events),
    .mode_o       (mode)
  );

  dram_model #(
    .MEM_LATENCY_P (MEM_LATENCY_P)
  ) u_dram_model (
    .clk          (clk),
    .reset        (reset),
    .req_i        (mem_req),
    .req_valid_i  (mem_req_valid),
    .req_ready_o  (mem_req_ready),
    .resp_o       (mem_resp),
    .resp_valid_o (mem_resp_valid)
  );

endmodule

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'ha952;
localparam int IDX_W = $clog2(SETS_P);
localparam int TAG_W = MEM_ADDR_W - IDX_W;

logic [31:0] lfsr_state = LFSR_SEED;

// shadow memory and line tags, line data always equals memory
bit [DATA_W-1:0]   sh_mem [2**MEM_ADDR_W];
bit                sh_valid [SETS_P];
logic [TAG_W-1:0]  sh_tag [SETS_P];
logic [DATA_W-1:0] sh_hits = '0;
logic [DATA_W-1:0] sh_misses = '0;
logic              sh_bypass = 1'b0;
logic              sh_no_mem = 1'b0;
logic              sh_err = 1'b0;

// x^32 + x^22 + x^2 + x + 1, right shifting
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic logic [DATA_W-1:0] apply_mask(
  input logic [DATA_W-1:0] old_word,
  input logic [DATA_W-1:0] new_word,
  input logic [MASK_W-1:0] mask
);
  logic [DATA_W-1:0] bit_sel;
  for (int b = 0; b < DATA_W; b++) begin
    bit_sel[b] = mask[b / 8];
  end
  return (old_word & ~bit_sel) | (new_word & bit_sel);
endfunction

// expected response, shadow state moves on as a side effect
function automatic link_resp_s ref_model(input link_req_s r);
  link_resp_s            res;
  logic [MEM_ADDR_W-1:0] a;
  logic [IDX_W-1:0]      idx;
  logic [TAG_W-1:0]      tag;
  logic                  line_hit;
  cfg_reg_e              reg_sel;
  res.load_id = r.load_id;
  res.data    = '0;
  a           = r.addr[MEM_ADDR_W-1:0];
  idx         = a[IDX_W-1:0];
  tag         = a[MEM_ADDR_W-1:IDX_W];
  line_hit    = sh_valid[idx] && (sh_tag[idx] == tag);
  reg_sel     = cfg_reg_e'(r.addr[1:0]);
  case (r.op)
    LOAD: begin
      if (line_hit && !sh_bypass) begin
        sh_hits  = sh_hits + 1;
        res.data = sh_mem[a];
      end else begin
        sh_misses = sh_misses + 1;
        if (sh_no_mem) begin
          sh_err = 1'b1;
        end else begin
          res.data = sh_mem[a];
          if (!sh_bypass) begin
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tag;
          end
        end
      end
    end
    STORE: begin
      if (sh_no_mem) begin
        sh_err = 1'b1;
      end else begin
        sh_mem[a] = apply_mask(sh_mem[a], r.payload.data, r.mask);
      end
    end
    CFG_RD: begin
      case (reg_sel)
        MODE:    res.data = {{(DATA_W-2){1'b0}}, sh_no_mem, sh_bypass};
        HITS:    res.data = sh_hits;
        MISSES:  res.data = sh_misses;
        default: res.data = {{(DATA_W-1){1'b0}}, sh_err};
      endcase
    end
    default: begin
      if (reg_sel == MODE) begin
        sh_bypass = r.payload.cfg.bypass;
        sh_no_mem = r.payload.cfg.no_mem;
        if (r.payload.cfg.clear) begin
          sh_hits   = '0;
          sh_misses = '0;
        end
      end else if (reg_sel == ERR) begin
        sh_err = 1'b0;
      end
    end
  endcase
  return res;
endfunction

task automatic check_resp(input string name, input link_resp_s want, input link_resp_s got);
  if (got !== want) begin
    $display("[FAIL] %s: expected id %0d data %h, actual id %0d data %h",
             name, want.load_id, want.data, got.load_id, got.data);
    $display("tests failed");
    $fatal(1, "response mismatch");
  end
endtask

task automatic check_word(input string name, input logic [DATA_W-1:0] want,
                          input logic [DATA_W-1:0] got);
  if (got !== want) begin
    $display("[FAIL] %s: expected %h, actual %h", name, want, got);
    $display("tests failed");
    $fatal(1, "word mismatch");
  end
endtask

`endif

// File: tb/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import mem_link_pkg::*; ();

  localparam int SETS_P        = 16;
  localparam int MEM_LATENCY_P = 3;
  localparam int CLK_PERIOD    = 40;

  localparam int N_LS       = 64;
  localparam int N_HM       = 13;
  localparam int N_BYP      = 12;
  localparam int N_NOMEM    = 11;
  localparam int N_BP       = 48;
  localparam int TOTAL_REQS = N_LS + N_HM + N_BYP + N_NOMEM + N_BP;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * (MEM_LATENCY_P + 8) + 200;

  logic       clk;
  logic       reset;
  link_req_s  req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  link_resp_s resp_o;
  logic       resp_valid_o;
  logic       resp_ready_i;

  link_resp_s exp_q [$];
  link_resp_s last_resp;
  string      cur_test = "reset";
  logic [LOAD_ID_W-1:0] next_id = '0;
  logic       bp_en = 1'b0;
  logic [31:0] bp_state;

  `include "tb_ref_model.svh"

  mem_subsys_top #(
    .SETS_P        (SETS_P),
    .MEM_LATENCY_P (MEM_LATENCY_P)
  ) dut (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * TIMEOUT_CYCLES);
    $display("watchdog expired after %0d cycles in test %s, the DUT stopped responding",
             TIMEOUT_CYCLES, cur_test);
    $display("tests failed");
    $fatal(1, "timeout");
  end

  // response back-pressure from its own LFSR stream
  initial begin
    resp_ready_i = 1'b1;
    bp_state     = LFSR_SEED;
    forever begin
      @(negedge clk);
      if (bp_en) begin
        bp_state     = lfsr_next(bp_state);
        resp_ready_i = bp_state[0];
      end else begin
        resp_ready_i = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    link_resp_s want;
    if (reset && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("response with load_id %0d arrived while no request was outstanding",
                 resp_o.load_id);
        $display("tests failed");
        $fatal(1, "unexpected response");
      end else begin
        want = exp_q.pop_front();
        check_resp(cur_test, want, resp_o);
        last_resp = resp_o;
      end
    end
  end

  // called and returns at a falling edge
  task automatic send_req(input link_req_s r);
    exp_q.push_back(ref_model(r));
    req_i       = r;
    req_valid_i = 1'b1;
    while (!req_ready_o) @(negedge clk);
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic issue(input link_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [MASK_W-1:0] mask, input logic [DATA_W-1:0] data);
    link_req_s r;
    r.op           = op;
    r.addr         = addr;
    r.mask         = mask;
    r.payload.data = data;
    r.load_id      = next_id;
    next_id        = next_id + 1'b1;
    send_req(r);
  endtask

  task automatic issue_load(input logic [ADDR_W-1:0] addr);
    issue(LOAD, addr, '0, '0);
  endtask

  task automatic issue_store(input logic [ADDR_W-1:0] addr, input logic [MASK_W-1:0] mask,
                             input logic [DATA_W-1:0] data);
    issue(STORE, addr, mask, data);
  endtask

  task automatic read_cfg(input cfg_reg_e idx);
    issue(CFG_RD, {1'b1, {(ADDR_W-3){1'b0}}, idx}, '0, '0);
  endtask

  task automatic write_cfg(input cfg_reg_e idx, input logic bypass, input logic no_mem,
                           input logic clear);
    cfg_fields_s f;
    f        = '0;
    f.bypass = bypass;
    f.no_mem = no_mem;
    f.clear  = clear;
    issue(CFG_WR, {1'b1, {(ADDR_W-3){1'b0}}, idx}, '0, f);
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic read_cfg_expect(input cfg_reg_e idx, input logic [DATA_W-1:0] want,
                                 input string name);
    read_cfg(idx);
    drain_responses();
    check_word(name, want, last_resp.data);
  endtask

  task automatic load_expect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] want,
                             input string name);
    issue_load(addr);
    drain_responses();
    check_word(name, want, last_resp.data);
  endtask

  task automatic run_load_store_test();
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
    logic [DATA_W-1:0] data;
    cur_test = "load after store";
    // second round stores onto filled lines
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 16; i++) begin
        addr = 16'h0100 | 16'(rand_bits(6));
        mask = MASK_W'(rand_bits(4));
        data = rand_bits(32);
        issue_store(addr, mask, data);
      end
      for (int i = 0; i < 16; i++) begin
        addr = 16'h0100 | 16'(rand_bits(6));
        issue_load(addr);
      end
    end
    drain_responses();
  endtask

  task automatic run_hit_miss_test();
    cur_test = "hit and miss accounting";
    write_cfg(MODE, 1'b0, 1'b0, 1'b1);
    // same index 3 with different tags
    issue_load(16'h0203);
    repeat (3) issue_load(16'h0203);
    issue_load(16'h0213);
    issue_load(16'h0203);
    issue_load(16'h0203);
    read_cfg_expect(HITS, 32'd4, "hit count");
    read_cfg_expect(MISSES, 32'd3, "miss count");
    write_cfg(MODE, 1'b0, 1'b0, 1'b1);
    read_cfg_expect(HITS, 32'd0, "hit count after clear");
    read_cfg_expect(MISSES, 32'd0, "miss count after clear");
  endtask

  task automatic run_bypass_test();
    cur_test = "bypass mode";
    write_cfg(MODE, 1'b1, 1'b0, 1'b1);
    issue_load(16'h0203);
    issue_load(16'h0203);
    issue_load(16'h0213);
    issue_store(16'h0213, 4'hf, rand_bits(32));
    read_cfg_expect(HITS, 32'd0, "hits in bypass");
    read_cfg_expect(MISSES, 32'd3, "misses in bypass");
    write_cfg(MODE, 1'b0, 1'b0, 1'b1);
    // line 3 still holds 0x0203
    issue_load(16'h0203);
    issue_load(16'h0213);
    read_cfg_expect(HITS, 32'd1, "hits after bypass");
    read_cfg_expect(MISSES, 32'd1, "misses after bypass");
  endtask

  task automatic run_no_mem_test();
    cur_test = "no-memory mode";
    issue_store(16'h0305, 4'hf, 32'h1234_5678);
    write_cfg(MODE, 1'b0, 1'b1, 1'b0);
    read_cfg_expect(ERR, 32'd0, "error flag before access");
    load_expect(16'h0305, 32'd0, "miss load with no memory");
    issue_store(16'h0305, 4'hf, 32'hdead_beef);
    read_cfg_expect(ERR, 32'd1, "error flag after access");
    issue_load(16'h0213);
    write_cfg(MODE, 1'b0, 1'b0, 1'b0);
    load_expect(16'h0305, 32'h1234_5678, "memory kept through no-memory mode");
    write_cfg(ERR, 1'b0, 1'b0, 1'b0);
    read_cfg_expect(ERR, 32'd0, "error flag after clear");
  endtask

  task automatic run_backpressure_test();
    logic [2:0]        kind;
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
    logic [DATA_W-1:0] data;
    cur_test = "back-pressure";
    @(posedge clk);
    bp_en = 1'b1;
    @(negedge clk);
    for (int i = 0; i < N_BP; i++) begin
      kind = 3'(rand_bits(3));
      addr = 16'h0100 | 16'(rand_bits(5));
      if (kind < 3'd4) begin
        issue_load(addr);
      end else if (kind < 3'd7) begin
        mask = MASK_W'(rand_bits(4));
        data = rand_bits(32);
        issue_store(addr, mask, data);
      end else begin
        read_cfg(rand_bits(1) ? HITS : MISSES);
      end
    end
    drain_responses();
    @(posedge clk);
    bp_en = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    reset       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    @(negedge clk);

    run_load_store_test();
    run_hit_miss_test();
    run_bypass_test();
    run_no_mem_test();
    run_backpressure_test();
    drain_responses();

    $display("all tests passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+tb
common/mem_link_pkg.sv
rtl/link_fifo.sv
vcache/vcache_bank.sv
vcache/vcache_csr.sv
rtl/dram_model.sv
rtl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - common/mem_link_pkg.sv
  - rtl/link_fifo.sv
  - vcache/vcache_bank.sv
  - vcache/vcache_csr.sv
  - rtl/dram_model.sv
  - rtl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mem_subsys.sv
